// File: Bender.yml
package:
  name: load_unit

sources:
  - files:
      - hw/ld_pkg.sv
      - hw/ld_req_fsm.sv
      - hw/ld_buffer.sv
      - hw/ld_result_align.sv
      - hw/load_unit.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tb_dcache_model.sv
      - verif/tb_load_unit.sv

// File: hw/ld_buffer.sv
/* load buffer: tracks outstanding loads by cache request id, allocates the
   lowest free slot and marks loads issued before a flush */
`default_nettype none

module ld_buffer (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic                           flush_i,
  // allocation side
  input  wire logic                           alloc_i,
  input  wire ld_pkg::ldbuf_entry_t           alloc_entry_i,
  output logic [ld_pkg::LDBUF_ID_W-1:0]       free_id_o,
  output logic                                full_o,
  // response side
  input  wire logic                           rsp_valid_i,
  input  wire logic [ld_pkg::LDBUF_ID_W-1:0]  rsp_id_i,
  input  wire logic                           kill_i,
  output ld_pkg::ldbuf_entry_t                rd_entry_o,
  output logic                                rd_valid_o
);

  logic [ld_pkg::NR_LDBUF-1:0]    valid_d, valid_q;
  logic [ld_pkg::NR_LDBUF-1:0]    flushed_d, flushed_q;
  logic [ld_pkg::LDBUF_ID_W-1:0]  last_id_q;
  ld_pkg::ldbuf_entry_t           entry_q [ld_pkg::NR_LDBUF];

  assign full_o = &valid_q;

  // lowest free slot wins, scanning from the top so the last hit is kept
  always_comb begin : free_search
    free_id_o = '0;
    for (int i = ld_pkg::NR_LDBUF - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        free_id_o = i[ld_pkg::LDBUF_ID_W-1:0];
      end
    end
  end

  always_comb begin : flags_comb
    valid_d   = valid_q;
    flushed_d = flushed_q;
    // everything in flight now belongs to the squashed path
    if (flush_i) begin
      flushed_d = '1;
    end
    if (rsp_valid_i) begin
      valid_d[rsp_id_i] = 1'b0;
    end
    // a fresh load in a slot starts out unflushed
    if (alloc_i) begin
      valid_d[free_id_o]   = 1'b1;
      flushed_d[free_id_o] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : flags_ff
    if (!rst_ni) begin
      valid_q   <= '0;
      flushed_q <= '0;
      last_id_q <= '0;
    end else begin
      valid_q   <= valid_d;
      flushed_q <= flushed_d;
      if (alloc_i) begin
        last_id_q <= free_id_o;
      end
    end
  end

  always_ff @(posedge clk_i) begin : entry_ff
    if (alloc_i) begin
      entry_q[free_id_o] <= alloc_entry_i;
    end
  end

  // ------------------------------
  // response lookup
  // ------------------------------
  assign rd_entry_o = entry_q[rsp_id_i];

  // a kill only hits the most recent load, whose tag is the one being killed
  assign rd_valid_o = rsp_valid_i & ~flushed_q[rsp_id_i] & ~flush_i &
                      ~(kill_i && (rsp_id_i == last_id_q));

endmodule

`default_nettype wire

// File: hw/ld_pkg.sv
/* load unit package: widths, load opcodes, FSM states and the packed structs
   shared by the request FSM, the load buffer, the aligner and the cache port */
`default_nettype none

package ld_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int unsigned XLEN       = 64;
  localparam int unsigned XLEN_BYTES = XLEN / 8;
  localparam int unsigned OFFSET_W   = 3;
  localparam int unsigned ADDR_W     = 32;
  // index is address bits 11..0, the tag is everything above it
  localparam int unsigned INDEX_W    = 12;
  localparam int unsigned TAG_W      = ADDR_W - INDEX_W;
  localparam int unsigned TRANS_ID_W = 3;
  // four loads in flight, so the cache request id is two bits
  localparam int unsigned NR_LDBUF   = 4;
  localparam int unsigned LDBUF_ID_W = 2;

  // ------------------------------
  // encodings
  // ------------------------------
  // signed and unsigned variants of each access size
  typedef enum logic [2:0] {
    LD, LW, LWU, LH, LHU, LB, LBU
  } ld_op_e;

  typedef enum logic [1:0] {
    IDLE, WAIT_GNT, SEND_TAG, WAIT_FLUSH
  } ld_state_e;

  // ------------------------------
  // structs
  // ------------------------------
  typedef struct packed {
    logic [TRANS_ID_W-1:0] trans_id;
    logic [ADDR_W-1:0]     addr;
    ld_op_e                op;
  } ld_req_t;

  // what the buffer keeps per outstanding load to realign the answer later
  typedef struct packed {
    logic [TRANS_ID_W-1:0] trans_id;
    logic [OFFSET_W-1:0]   offset;
    ld_op_e                op;
  } ldbuf_entry_t;

  typedef struct packed {
    logic                  data_req;
    logic [INDEX_W-1:0]    address_index;
    logic [LDBUF_ID_W-1:0] data_id;
    logic                  tag_valid;
    logic [TAG_W-1:0]      address_tag;
    logic                  kill_req;
  } dcache_req_t;

  typedef struct packed {
    logic                  data_gnt;
    logic                  data_rvalid;
    logic [LDBUF_ID_W-1:0] data_rid;
    logic [XLEN-1:0]       data_rdata;
  } dcache_rsp_t;

  typedef struct packed {
    logic [TRANS_ID_W-1:0] trans_id;
    logic [XLEN-1:0]       data;
  } ld_result_t;

endpackage

`default_nettype wire

// File: hw/ld_req_fsm.sv
/* load request FSM: drives the data cache index and tag phases, pops the
   input on the index grant and kills the tag in flight on a flush */
`default_nettype none

module ld_req_fsm (
  input  wire logic                           clk_i,
  input  wire logic                           rst_ni,
  input  wire logic                           flush_i,
  // load request input
  input  wire logic                           valid_i,
  input  wire ld_pkg::ld_req_t                req_i,
  output logic                                ready_o,
  // load buffer status
  input  wire logic                           ldbuf_full_i,
  input  wire logic [ld_pkg::LDBUF_ID_W-1:0]  ldbuf_free_id_i,
  // data cache request side
  input  wire logic                           dcache_gnt_i,
  output ld_pkg::dcache_req_t                 dcache_req_o,
  // allocation into the load buffer
  output logic                                alloc_o,
  output ld_pkg::ldbuf_entry_t                alloc_entry_o
);

  ld_pkg::ld_state_e           state_d, state_q;
  logic                        data_req;
  logic                        tag_valid;
  logic                        kill_req;
  logic                        issue;
  logic                        grant;
  logic [ld_pkg::TAG_W-1:0]    tag_q;

  // a new index can go out only with room in the buffer and no flush
  assign issue = valid_i & ~ldbuf_full_i & ~flush_i;
  assign grant = data_req & dcache_gnt_i;

  // ------------------------------
  // next state
  // ------------------------------
  always_comb begin : fsm_comb
    state_d   = state_q;
    data_req  = 1'b0;
    tag_valid = 1'b0;
    kill_req  = 1'b0;

    case (state_q)
      // the tag of the previous grant goes out while the next index may be issued
      ld_pkg::IDLE, ld_pkg::SEND_TAG: begin
        tag_valid = (state_q == ld_pkg::SEND_TAG);
        state_d   = ld_pkg::IDLE;
        if (issue) begin
          data_req = 1'b1;
          state_d  = dcache_gnt_i ? ld_pkg::SEND_TAG : ld_pkg::WAIT_GNT;
        end
      end

      // hold the index until the cache grants it
      ld_pkg::WAIT_GNT: begin
        data_req = ~flush_i;
        if (grant) begin
          state_d = ld_pkg::SEND_TAG;
        end
      end

      // kill whatever tag the cache may still expect, then start over
      ld_pkg::WAIT_FLUSH: begin
        kill_req  = 1'b1;
        tag_valid = 1'b1;
        state_d   = ld_pkg::IDLE;
      end

      default: state_d = ld_pkg::IDLE;
    endcase

    // flush overrides everything else
    if (flush_i) begin
      state_d = ld_pkg::WAIT_FLUSH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_ff
    if (!rst_ni) begin
      state_q <= ld_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // the tag is sampled at the grant since req_i may change right after
  always_ff @(posedge clk_i) begin : tag_ff
    if (grant) begin
      tag_q <= req_i.addr[ld_pkg::ADDR_W-1:ld_pkg::INDEX_W];
    end
  end

  // ------------------------------
  // outputs
  // ------------------------------
  assign ready_o = grant;
  assign alloc_o = grant;

  assign alloc_entry_o.trans_id = req_i.trans_id;
  assign alloc_entry_o.offset   = req_i.addr[ld_pkg::OFFSET_W-1:0];
  assign alloc_entry_o.op       = req_i.op;

  // request id of the cache access is the slot the buffer will fill
  assign dcache_req_o.data_req      = data_req;
  assign dcache_req_o.address_index = req_i.addr[ld_pkg::INDEX_W-1:0];
  assign dcache_req_o.data_id       = ldbuf_free_id_i;
  assign dcache_req_o.tag_valid     = tag_valid;
  assign dcache_req_o.address_tag   = tag_q;
  assign dcache_req_o.kill_req      = kill_req;

endmodule

`default_nettype wire

// File: hw/ld_result_align.sv
/* result aligner: shifts the returned cache word down to the load's byte
   offset and sign- or zero-extends it by load type */
`default_nettype none

module ld_result_align (
  input  wire logic [ld_pkg::XLEN-1:0]  rdata_i,
  input  wire ld_pkg::ldbuf_entry_t     entry_i,
  output ld_pkg::ld_result_t            result_o
);

  logic [ld_pkg::XLEN-1:0]        shifted;
  logic [ld_pkg::XLEN_BYTES-1:0]  sign_bits;
  logic [ld_pkg::OFFSET_W-1:0]    sign_offset;
  logic                           is_signed;
  logic                           sign_bit;

  // byte offset times eight gives the bit shift
  assign shifted = rdata_i >> {entry_i.offset, 3'b000};

  // ------------------------------
  // sign bit, in parallel to the shift
  // ------------------------------
  // top bit of every byte in the raw word
  for (genvar i = 0; i < ld_pkg::XLEN_BYTES; i++) begin : gen_sign_bits
    assign sign_bits[i] = rdata_i[i*8+7];
  end

  assign is_signed = entry_i.op inside {ld_pkg::LW, ld_pkg::LH, ld_pkg::LB};

  // the field's top byte sits three or one bytes above the offset for words and halves
  always_comb begin : sign_sel
    case (entry_i.op)
      ld_pkg::LW, ld_pkg::LWU: sign_offset = entry_i.offset + 3'd3;
      ld_pkg::LH, ld_pkg::LHU: sign_offset = entry_i.offset + 3'd1;
      default:                 sign_offset = entry_i.offset;
    endcase
  end

  // unsigned loads pull the fill bit to zero
  assign sign_bit = is_signed & sign_bits[sign_offset];

  // ------------------------------
  // extension
  // ------------------------------
  always_comb begin : ext_mux
    case (entry_i.op)
      ld_pkg::LW, ld_pkg::LWU: result_o.data = {{32{sign_bit}}, shifted[31:0]};
      ld_pkg::LH, ld_pkg::LHU: result_o.data = {{48{sign_bit}}, shifted[15:0]};
      ld_pkg::LB, ld_pkg::LBU: result_o.data = {{56{sign_bit}}, shifted[7:0]};
      default:                 result_o.data = shifted;
    endcase
  end

  assign result_o.trans_id = entry_i.trans_id;

endmodule

`default_nettype wire

// File: hw/load_unit.sv
/* load unit top: request FSM, load buffer and result aligner around a
   two-phase data cache port with out-of-order responses */
`default_nettype none

module load_unit (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 flush_i,
  // load requests
  input  wire logic                 valid_i,
  input  wire ld_pkg::ld_req_t      req_i,
  output logic                      ready_o,
  // data cache
  output ld_pkg::dcache_req_t       dcache_req_o,
  input  wire ld_pkg::dcache_rsp_t  dcache_rsp_i,
  // results, no back-pressure
  output logic                      valid_o,
  output ld_pkg::ld_result_t        result_o
);

  logic                           alloc;
  ld_pkg::ldbuf_entry_t           alloc_entry;
  logic [ld_pkg::LDBUF_ID_W-1:0]  free_id;
  logic                           ldbuf_full;
  ld_pkg::ldbuf_entry_t           rd_entry;

  ld_req_fsm i_ld_req_fsm (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .valid_i         (valid_i),
    .req_i           (req_i),
    .ready_o         (ready_o),
    .ldbuf_full_i    (ldbuf_full),
    .ldbuf_free_id_i (free_id),
    .dcache_gnt_i    (dcache_rsp_i.data_gnt),
    .dcache_req_o    (dcache_req_o),
    .alloc_o         (alloc),
    .alloc_entry_o   (alloc_entry)
  );

  // the response id indexes the buffer directly
  ld_buffer i_ld_buffer (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .alloc_i       (alloc),
    .alloc_entry_i (alloc_entry),
    .free_id_o     (free_id),
    .full_o        (ldbuf_full),
    .rsp_valid_i   (dcache_rsp_i.data_rvalid),
    .rsp_id_i      (dcache_rsp_i.data_rid),
    .kill_i        (dcache_req_o.kill_req),
    .rd_entry_o    (rd_entry),
    .rd_valid_o    (valid_o)
  );

  ld_result_align i_ld_result_align (
    .rdata_i  (dcache_rsp_i.data_rdata),
    .entry_i  (rd_entry),
    .result_o (result_o)
  );

endmodule

`default_nettype wire

// File: load_unit.f
+incdir+verif
hw/ld_pkg.sv
hw/ld_req_fsm.sv
hw/ld_buffer.sv
hw/ld_result_align.sv
hw/load_unit.sv
verif/tb_dcache_model.sv
verif/tb_load_unit.sv

// File: verif/tb_hash.svh
/* data word hash shared by the cache model and the checker, so every word
   address maps to one fixed 64-bit pattern */

// the byte offset is dropped since the cache returns the whole aligned word
function automatic logic [63:0] word_hash(input logic [31:0] addr);
  logic [31:0] word_addr;
  word_addr = {addr[31:3], 3'b000};
  return {word_addr * 32'h9e3779b1, (word_addr ^ 32'hc2b2ae35) * 32'h27d4eb2f};
endfunction

// File: verif/tb_dcache_model.sv
/* behavioral data cache: grants the index phase at random, takes the tag one
   cycle later and answers each load after 1 to 8 cycles in any order */
`default_nettype none

module tb_dcache_model (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 gnt_en_i,
  input  wire logic                 rsp_en_i,
  input  wire ld_pkg::dcache_req_t  req_i,
  output ld_pkg::dcache_rsp_t       rsp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  `include "tb_hash.svh"

  logic [ld_pkg::NR_LDBUF-1:0]    pending_q;
  logic [ld_pkg::NR_LDBUF-1:0]    tag_seen_q;
  logic [ld_pkg::INDEX_W-1:0]     index_q [ld_pkg::NR_LDBUF];
  logic [ld_pkg::TAG_W-1:0]       tag_q [ld_pkg::NR_LDBUF];
  logic [2:0]                     delay_q [ld_pkg::NR_LDBUF];
  logic [ld_pkg::LDBUF_ID_W-1:0]  last_id_q;
  logic [ld_pkg::LDBUF_ID_W-1:0]  rsp_id;
  logic [ld_pkg::TAG_W-1:0]       rsp_tag;
  logic                           rsp_valid;
  logic                           gnt_q;
  integer                         seed = 32'hb0082386;

  // one answer per cycle, lowest ready slot first
  always_comb begin : rsp_pick
    rsp_valid = 1'b0;
    rsp_id    = '0;
    for (int i = ld_pkg::NR_LDBUF - 1; i >= 0; i--) begin
      if (rsp_en_i && pending_q[i] && (delay_q[i] == 3'd0)) begin
        rsp_valid = 1'b1;
        rsp_id    = 2'(i);
      end
    end
  end

  // an answer in the tag cycle sees the tag straight from the port
  assign rsp_tag = tag_seen_q[rsp_id] ? tag_q[rsp_id] : req_i.address_tag;

  assign rsp_o.data_gnt    = gnt_q;
  assign rsp_o.data_rvalid = rsp_valid;
  assign rsp_o.data_rid    = rsp_id;
  assign rsp_o.data_rdata  = rsp_valid ? word_hash({rsp_tag, index_q[rsp_id]}) : '0;

  always @(posedge clk_i or negedge rst_ni) begin : model_ff
    if (!rst_ni) begin
      pending_q  <= '0;
      tag_seen_q <= '0;
      last_id_q  <= '0;
      gnt_q      <= 1'b0;
    end else begin
      // grant three cycles out of four on average
      gnt_q <= gnt_en_i && (({$random(seed)} % 4) != 0);
      for (int i = 0; i < ld_pkg::NR_LDBUF; i++) begin
        if (pending_q[i] && (delay_q[i] != 3'd0)) begin
          delay_q[i] <= delay_q[i] - 3'd1;
        end
      end
      if (rsp_valid) begin
        pending_q[rsp_id] <= 1'b0;
      end
      // the tag belongs to the index granted in the cycle before
      if (req_i.tag_valid && !req_i.kill_req) begin
        tag_q[last_id_q]      <= req_i.address_tag;
        tag_seen_q[last_id_q] <= 1'b1;
      end
      if (req_i.data_req && gnt_q) begin
        pending_q[req_i.data_id]  <= 1'b1;
        tag_seen_q[req_i.data_id] <= 1'b0;
        index_q[req_i.data_id]    <= req_i.address_index;
        delay_q[req_i.data_id]    <= 3'({$random(seed)} % 8);
        last_id_q                 <= req_i.data_id;
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_load_unit.sv
/* load unit testbench: runs loads through a random data cache model and
   checks every result against a reference of the load extension rules */
`default_nettype none

module tb_load_unit;
  timeunit 1ns;
  timeprecision 1ps;

  `include "tb_hash.svh"

  localparam int unsigned CLK_PERIOD = 4;
  // 29 aligned sweeps, 1 held grant, 12 back to back, 5 full buffer, 8 flush
  localparam int unsigned NR_LOADS   = 55;
  localparam int unsigned NR_IDS     = 2 ** ld_pkg::TRANS_ID_W;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 flush;
  logic                 ld_valid;
  ld_pkg::ld_req_t      ld_req;
  logic                 ld_ready;
  ld_pkg::dcache_req_t  dc_req;
  ld_pkg::dcache_rsp_t  dc_rsp;
  logic                 res_valid;
  ld_pkg::ld_result_t   result;
  logic                 gnt_en;
  logic                 rsp_en;
  logic [NR_IDS-1:0]    exp_valid;
  ld_pkg::ld_result_t   exp_result [NR_IDS];
  integer               seed = 32'hb0082386;
  int unsigned          error_count = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  load_unit i_load_unit (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .flush_i      (flush),
    .valid_i      (ld_valid),
    .req_i        (ld_req),
    .ready_o      (ld_ready),
    .dcache_req_o (dc_req),
    .dcache_rsp_i (dc_rsp),
    .valid_o      (res_valid),
    .result_o     (result)
  );

  tb_dcache_model i_dcache_model (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .gnt_en_i (gnt_en),
    .rsp_en_i (rsp_en),
    .req_i    (dc_req),
    .rsp_o    (dc_rsp)
  );

  // ------------------------------
  // reference and checks
  // ------------------------------
  function automatic logic [63:0] expected_data(input ld_pkg::ld_op_e op,
                                                input logic [2:0] offset,
                                                input logic [63:0] word);
    logic [63:0] field;
    field = word >> (8 * offset);
    case (op)
      ld_pkg::LW:  return {{32{field[31]}}, field[31:0]};
      ld_pkg::LWU: return {32'h0, field[31:0]};
      ld_pkg::LH:  return {{48{field[15]}}, field[15:0]};
      ld_pkg::LHU: return {48'h0, field[15:0]};
      ld_pkg::LB:  return {{56{field[7]}}, field[7:0]};
      ld_pkg::LBU: return {56'h0, field[7:0]};
      default:     return field;
    endcase
  endfunction

  function automatic int op_size(input ld_pkg::ld_op_e op);
    case (op)
      ld_pkg::LD:              return 8;
      ld_pkg::LW, ld_pkg::LWU: return 4;
      ld_pkg::LH, ld_pkg::LHU: return 2;
      default:                 return 1;
    endcase
  endfunction

  task automatic report_failure(input string what);
    error_count++;
    $display("%s", what);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_result(input ld_pkg::ld_result_t got, input ld_pkg::ld_result_t exp);
    if (got !== exp) begin
      report_failure($sformatf("Fail result_o got %h expected %h", got, exp));
    end
  endtask

  task automatic check_trans_id(input logic [ld_pkg::TRANS_ID_W-1:0] id);
    if (exp_valid[id] !== 1'b1) begin
      report_failure($sformatf("valid_o came for trans_id %h with no load outstanding", id));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("Fail %s got %h expected %h", name, got, exp));
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin : compare
    if (rst_n && res_valid) begin
      check_trans_id(result.trans_id);
      check_result(result, exp_result[result.trans_id]);
      exp_valid[result.trans_id] = 1'b0;
    end
  end

  initial begin : watchdog
    #(NR_LOADS * 200 * CLK_PERIOD);
    report_failure("timeout: the loads did not complete in time");
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // trans_id is the lowest one without a load in flight
  task automatic drive_req(input logic [31:0] addr, input ld_pkg::ld_op_e op);
    int id;
    id = 0;
    while (exp_valid[id]) begin
      id++;
    end
    ld_req.trans_id = 3'(id);
    ld_req.addr     = addr;
    ld_req.op       = op;
    ld_valid        = 1'b1;
  endtask

  // the expectation is set before the earliest answer, in the tag cycle
  task automatic wait_accept();
    do begin
      @(negedge clk);
    end while (!ld_ready);
    next_cycle();
    ld_valid = 1'b0;
    exp_result[ld_req.trans_id].trans_id = ld_req.trans_id;
    exp_result[ld_req.trans_id].data     = expected_data(ld_req.op, ld_req.addr[2:0],
                                                         word_hash(ld_req.addr));
    exp_valid[ld_req.trans_id] = 1'b1;
  endtask

  task automatic issue_load(input logic [31:0] addr, input ld_pkg::ld_op_e op);
    drive_req(addr, op);
    wait_accept();
  endtask

  task automatic expect_stall(input int cycles, input logic exp_req);
    repeat (cycles) begin
      @(negedge clk);
      check_flag("ready_o", ld_ready, 1'b0);
      check_flag("data_req", dc_req.data_req, exp_req);
    end
  endtask

  task automatic drain();
    while (exp_valid != '0) begin
      @(negedge clk);
    end
    next_cycle();
  endtask

  initial begin : stimulus
    ld_pkg::ld_op_e op;
    logic [31:0]    addr;
    rst_n     = 1'b0;
    flush     = 1'b0;
    ld_valid  = 1'b0;
    ld_req    = '0;
    gnt_en    = 1'b1;
    rsp_en    = 1'b1;
    exp_valid = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // quiet outputs right after reset
    repeat (3) begin
      @(negedge clk);
      check_flag("ready_o", ld_ready, 1'b0);
      check_flag("valid_o", res_valid, 1'b0);
      check_flag("data_req", dc_req.data_req, 1'b0);
      check_flag("tag_valid", dc_req.tag_valid, 1'b0);
      check_flag("kill_req", dc_req.kill_req, 1'b0);
    end
    next_cycle();

    // every opcode at each naturally aligned offset
    for (int k = 0; k < 7; k++) begin
      op = ld_pkg::ld_op_e'(k);
      for (int off = 0; off < 8; off += op_size(op)) begin
        addr      = $random(seed);
        addr[2:0] = 3'(off);
        issue_load(addr, op);
      end
    end
    drain();

    // grants held off keep the index up and the input waiting
    gnt_en = 1'b0;
    next_cycle();
    drive_req($random(seed) & 32'hffff_fff8, ld_pkg::LD);
    expect_stall(10, 1'b1);
    next_cycle();
    gnt_en = 1'b1;
    wait_accept();
    drain();

    // back to back loads, answered out of order
    repeat (12) begin
      op        = ld_pkg::ld_op_e'({$random(seed)} % 7);
      addr      = $random(seed);
      addr[2:0] = addr[2:0] & 3'(~(op_size(op) - 1));
      issue_load(addr, op);
    end
    drain();

    // a full buffer holds the fifth load until an answer frees a slot
    rsp_en = 1'b0;
    repeat (4) begin
      issue_load($random(seed), ld_pkg::LBU);
    end
    drive_req($random(seed) & 32'hffff_fffe, ld_pkg::LHU);
    expect_stall(10, 1'b0);
    next_cycle();
    rsp_en = 1'b1;
    wait_accept();
    drain();

    // loads in flight at the flush stay silent, later ones return
    rsp_en = 1'b0;
    repeat (4) begin
      issue_load($random(seed), ld_pkg::LB);
    end
    rsp_en    = 1'b1;
    flush     = 1'b1;
    exp_valid = '0;
    next_cycle();
    flush = 1'b0;
    // the cycle after the flush kills the tag, and only that cycle
    @(negedge clk);
    check_flag("kill_req", dc_req.kill_req, 1'b1);
    check_flag("tag_valid", dc_req.tag_valid, 1'b1);
    @(negedge clk);
    check_flag("kill_req", dc_req.kill_req, 1'b0);
    next_cycle();
    repeat (4) begin
      issue_load($random(seed) & 32'hffff_fffc, ld_pkg::LW);
    end
    drain();
    repeat (16) next_cycle();

    if (error_count == 0) begin
      $display("No errors");
      $finish;
    end else begin
      report_failure("checks failed during the run");
    end
  end

endmodule

`default_nettype wire
